/* sources.f */
src/cpu_isa_pkg.sv
src/cpu_arch_pkg.sv
src/cpu_control.sv
src/cpu_pc.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_memory.sv
src/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - src/cpu_isa_pkg.sv
  - src/cpu_arch_pkg.sv
  - src/cpu_control.sv
  - src/cpu_pc.sv
  - src/cpu_regfile.sv
  - src/cpu_alu.sv
  - src/cpu_memory.sv
  - src/cpu_core.sv
  - target: test
    files:
      - tb/cpu_checker.sv
      - tb/tb_cpu_core.sv

/* tb/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core
  import cpu_isa_pkg::*;
();

  localparam int MAX_ROWS     = 64;
  localparam int DONE_TIMEOUT = 2000;

  logic        clk;
  logic        rst_n, run;
  logic        imem_we;
  logic [5:0]  imem_addr;
  logic [31:0] imem_data;
  logic [31:0] pc, wb_data;
  logic        retire, wb_valid;
  logic [3:0]  wb_addr, flags;

  // Program table with one row per instruction word
  logic [31:0] tbl_inst  [MAX_ROWS];
  logic        tbl_we    [MAX_ROWS];
  logic [3:0]  tbl_reg   [MAX_ROWS];
  logic [31:0] tbl_val   [MAX_ROWS];
  logic [3:0]  tbl_flags [MAX_ROWS];  // N Z C V after the row
  logic [31:0] tbl_pc    [MAX_ROWS];  // Next pc_o
  int          num_rows;

  logic [5:0]  row, last_row;
  logic        exp_we;
  logic [3:0]  exp_reg, exp_flags;
  logic [31:0] exp_val, exp_pc;
  logic        chk_done, chk_timeout;
  logic [15:0] chk_pass, chk_fail;

  assign last_row  = 6'(num_rows - 1);
  assign exp_we    = tbl_we[row];
  assign exp_reg   = tbl_reg[row];
  assign exp_val   = tbl_val[row];
  assign exp_flags = tbl_flags[row];
  assign exp_pc    = tbl_pc[row];

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;            // 4 ns period
  end

  cpu_core i_cpu_core (
    .clk, .rst_n_i(rst_n), .run_i(run),
    .imem_we_i(imem_we), .imem_addr_i(imem_addr), .imem_data_i(imem_data),
    .pc_o(pc), .retire_o(retire), .wb_valid_o(wb_valid), .wb_addr_o(wb_addr),
    .wb_data_o(wb_data), .flags_o(flags)
  );

  cpu_checker i_cpu_checker (
    .clk, .rst_n_i(rst_n), .run_i(run), .pc_i(pc), .retire_i(retire),
    .wb_valid_i(wb_valid), .wb_addr_i(wb_addr), .wb_data_i(wb_data), .flags_i(flags),
    .last_row_i(last_row), .exp_we_i(exp_we), .exp_reg_i(exp_reg), .exp_val_i(exp_val),
    .exp_flags_i(exp_flags), .exp_pc_i(exp_pc), .row_o(row), .done_o(chk_done),
    .timeout_o(chk_timeout), .pass_count_o(chk_pass), .fail_count_o(chk_fail)
  );

  // ************************************************************************
  // Instruction encoders
  // ************************************************************************
  function automatic logic [31:0] dp_imm(input cpu_cond_e cond, input cpu_opcode_e op,
      input int s, input int rn, input int rd, input int rot, input int imm8);
    return {cond, 3'b001, op, 1'(s), 4'(rn), 4'(rd), 4'(rot), 8'(imm8)};
  endfunction

  function automatic logic [31:0] dp_reg(input cpu_cond_e cond, input cpu_opcode_e op,
      input int s, input int rn, input int rd, input int shamt, input int sh, input int rm);
    return {cond, 3'b000, op, 1'(s), 4'(rn), 4'(rd), 5'(shamt), 2'(sh), 1'b0, 4'(rm)};
  endfunction

  function automatic logic [31:0] ld_st(input cpu_cond_e cond, input int u, input int l,
      input int rn, input int rd, input int off);
    return {cond, 3'b010, 1'b1, 1'(u), 2'b00, 1'(l), 4'(rn), 4'(rd), 12'(off)};
  endfunction

  function automatic logic [31:0] br(input cpu_cond_e cond, input int link, input int off);
    return {cond, 3'b101, 1'(link), 24'(off)};
  endfunction

  task automatic add_row(input logic [31:0] inst, input int we, input int rd,
                         input logic [31:0] val, input logic [3:0] nzcv);
    tbl_inst[num_rows]  = inst;
    tbl_we[num_rows]    = 1'(we);
    tbl_reg[num_rows]   = 4'(rd);
    tbl_val[num_rows]   = val;
    tbl_flags[num_rows] = nzcv;
    tbl_pc[num_rows]    = 32'(num_rows * 4 + 4);  // Straight-line successor
    num_rows++;
  endtask

  task automatic add_branch(input logic [31:0] inst, input int we, input int rd,
                            input logic [31:0] val, input logic [3:0] nzcv,
                            input logic [31:0] next_pc);
    add_row(inst, we, rd, val, nzcv);
    tbl_pc[num_rows - 1] = next_pc;
  endtask

  // Each row gives instruction, write flag, rd, value and NZCV, plus next PC for branches
  task automatic build_program();
    num_rows = 0;
    add_row(dp_imm(AL, OP_MOV, 0, 0, 1, 0, 8'h05), 1, 1, 32'h5, 4'b0000);
    add_row(dp_imm(AL, OP_MOV, 0, 0, 2, 4, 8'hAB), 1, 2, 32'hAB000000, 4'b0000);  // ROR 8
    add_row(dp_imm(AL, OP_ADD, 0, 1, 3, 0, 8'h0A), 1, 3, 32'hF, 4'b0000);
    add_row(dp_reg(AL, OP_SUB, 0, 3, 4, 0, SH_LSL, 1), 1, 4, 32'hA, 4'b0000);
    add_row(dp_imm(AL, OP_AND, 0, 3, 5, 0, 8'h06), 1, 5, 32'h6, 4'b0000);
    add_row(dp_imm(AL, OP_ORR, 0, 1, 6, 0, 8'h30), 1, 6, 32'h35, 4'b0000);
    add_row(dp_imm(AL, OP_EOR, 0, 3, 7, 0, 8'h05), 1, 7, 32'hA, 4'b0000);
    add_row(dp_imm(AL, OP_BIC, 0, 3, 8, 0, 8'h03), 1, 8, 32'hC, 4'b0000);
    add_row(dp_imm(AL, OP_MVN, 0, 0, 9, 0, 8'h00), 1, 9, 32'hFFFFFFFF, 4'b0000);
    add_row(dp_reg(AL, OP_MOV, 0, 0, 10, 4, SH_LSL, 1), 1, 10, 32'h50, 4'b0000);
    add_row(dp_reg(AL, OP_MOV, 0, 0, 11, 4, SH_LSR, 2), 1, 11, 32'h0AB00000, 4'b0000);
    add_row(dp_reg(AL, OP_MOV, 0, 0, 12, 8, SH_ASR, 2), 1, 12, 32'hFFAB0000, 4'b0000);
    add_row(dp_reg(AL, OP_MOV, 0, 0, 13, 1, SH_ROR, 1), 1, 13, 32'h80000002, 4'b0000);
    add_row(dp_imm(AL, OP_ADD, 1, 9, 0, 0, 8'h01), 1, 0, 32'h0, 4'b0110);  // Carry out
    add_row(dp_reg(AL, OP_SUB, 1, 1, 0, 0, SH_LSL, 3), 1, 0, 32'hFFFFFFF6, 4'b1000);
    add_row(dp_reg(AL, OP_ADD, 1, 2, 0, 0, SH_LSL, 2), 1, 0, 32'h56000000, 4'b0011);
    add_row(dp_reg(AL, OP_CMP, 1, 3, 0, 0, SH_LSL, 4), 0, 0, 32'h0, 4'b0010);
    add_row(dp_imm(AL, OP_TST, 1, 1, 0, 0, 8'h02), 0, 0, 32'h0, 4'b0110);
    add_row(dp_imm(AL, OP_TEQ, 1, 9, 0, 0, 8'h01), 0, 0, 32'h0, 4'b1010);
    add_row(dp_imm(AL, OP_BIC, 1, 1, 0, 0, 8'hFF), 1, 0, 32'h0, 4'b1010);  // Zero result but NZ held
    add_row(dp_imm(EQ, OP_MOV, 0, 0, 0, 0, 8'h01), 0, 0, 32'h0, 4'b1010);
    add_row(dp_imm(NE, OP_MOV, 0, 0, 0, 0, 8'h02), 1, 0, 32'h2, 4'b1010);
    add_row(dp_imm(GE, OP_MOV, 0, 0, 0, 0, 8'h03), 0, 0, 32'h0, 4'b1010);
    add_row(dp_imm(LT, OP_MOV, 0, 0, 0, 0, 8'h04), 1, 0, 32'h4, 4'b1010);
    add_row(dp_imm(HI, OP_MOV, 0, 0, 0, 0, 8'h05), 1, 0, 32'h5, 4'b1010);
    add_row(dp_imm(LS, OP_MOV, 0, 0, 0, 0, 8'h06), 0, 0, 32'h0, 4'b1010);
    add_row(dp_imm(EQ, OP_ADD, 1, 9, 0, 0, 8'h01), 0, 0, 32'h0, 4'b1010);  // Skipped S op
    add_row(dp_imm(AL, OP_CMP, 1, 1, 0, 0, 8'h05), 0, 0, 32'h0, 4'b0110);
    add_row(dp_imm(EQ, OP_MOV, 0, 0, 0, 0, 8'h07), 1, 0, 32'h7, 4'b0110);
    add_row(ld_st(AL, 1, 0, 10, 2, 8), 0, 0, 32'h0, 4'b0110);              // Address 0x58
    add_row(ld_st(AL, 0, 0, 10, 13, 8), 0, 0, 32'h0, 4'b0110);             // Address 0x48
    add_row(ld_st(AL, 1, 1, 10, 0, 8), 1, 0, 32'hAB000000, 4'b0110);
    add_row(ld_st(AL, 0, 1, 10, 0, 8), 1, 0, 32'h80000002, 4'b0110);
    add_branch(br(NE, 0, 5), 0, 0, 32'h0, 4'b0110, 32'h88);               // Not taken
    add_branch(br(AL, 1, -1), 1, 14, 32'h8C, 4'b0110, 32'h8C);
    add_branch(br(EQ, 0, 0), 0, 0, 32'h0, 4'b0110, 32'h94);               // Skips next
    add_row(dp_imm(AL, OP_MOV, 0, 0, 0, 0, 8'hEE), 1, 0, 32'hEE, 4'b0110);
    add_row(dp_imm(AL, OP_ADD, 0, 14, 0, 0, 8'h00), 1, 0, 32'h8C, 4'b0110);
    add_branch(br(AL, 0, -2), 0, 0, 32'h0, 4'b0110, 32'h98);              // Branch to self
  endtask

  // ************************************************************************
  // Reset, program load, run
  // ************************************************************************
  initial begin : stimulus
    int cycles;
    rst_n     = 1'b0;
    run       = 1'b0;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    build_program();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < num_rows; k++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= 6'(k);
      imem_data <= tbl_inst[k];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (4) @(posedge clk);
    run <= 1'b1;
    cycles = 0;
    while (!chk_done && cycles < DONE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    run <= 1'b0;
    if (!chk_done) $display("timeout: checker did not finish within %0d cycles", DONE_TIMEOUT);
    $display("tests passed: %0d, failed: %0d", chk_pass, chk_fail);
    if (chk_done && !chk_timeout && chk_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         run_i,
  input  wire  [31:0] pc_i,
  input  wire         retire_i,
  input  wire         wb_valid_i,
  input  wire  [3:0]  wb_addr_i,
  input  wire  [31:0] wb_data_i,
  input  wire  [3:0]  flags_i,         // N Z C V
  input  wire  [5:0]  last_row_i,
  input  wire         exp_we_i,        // Expected values of row_o
  input  wire  [3:0]  exp_reg_i,
  input  wire  [31:0] exp_val_i,
  input  wire  [3:0]  exp_flags_i,
  input  wire  [31:0] exp_pc_i,        // Next pc_o
  output logic [5:0]  row_o,
  output logic        done_o,
  output logic        timeout_o,
  output logic [15:0] pass_count_o,
  output logic [15:0] fail_count_o
);

  localparam int RETIRE_TIMEOUT = 40;  // Cycles per retire wait
  localparam int IDLE_LIMIT     = 400;

  int errs;                            // Errors in the current test

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, got);
      errs++;
    end
  endtask

  task automatic close_test(input string what);
    if (errs == 0) begin
      pass_count_o = pass_count_o + 1'b1;
      $display("%s: ok", what);
    end else begin
      fail_count_o = fail_count_o + 1'b1;
      $display("%s: %0d error(s)", what, errs);
    end
    errs = 0;
  endtask

  // Samples on falling edges, counts cycles until retire
  task automatic wait_retire(output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!retire_i && cycles < RETIRE_TIMEOUT);
  endtask

  initial begin : watch
    int   cycles;
    int   idx;
    logic first;
    logic finished;
    row_o        = '0;
    done_o       = 1'b0;
    timeout_o    = 1'b0;
    pass_count_o = '0;
    fail_count_o = '0;
    errs         = 0;
    cycles = 0;
    while (!rst_n_i && cycles < IDLE_LIMIT) begin
      @(negedge clk);
      cycles++;
    end

    // ************************************************************************
    // Quiet outputs until run rises
    // ************************************************************************
    cycles = 0;
    while (!run_i && cycles < IDLE_LIMIT) begin
      @(negedge clk);
      cycles++;
      compare_value("retire_o", 32'h0, 32'(retire_i));
      compare_value("wb_valid_o", 32'h0, 32'(wb_valid_i));
      compare_value("pc_o", 32'h0, pc_i);
    end
    if (!run_i) begin
      $display("run was never raised after reset");
      errs++;
    end
    close_test("idle after reset");

    // ************************************************************************
    // One row per retire, next row follows the expected PC
    // ************************************************************************
    idx      = 0;
    first    = 1'b1;
    finished = 1'b0;
    while (!finished) begin
      row_o = 6'(idx);
      wait_retire(cycles);
      if (!retire_i) begin
        $display("timeout at %0t ns: the core did not retire row %0d within %0d cycles",
                 $time, idx, RETIRE_TIMEOUT);
        timeout_o = 1'b1;
        errs++;
        close_test($sformatf("row %0d", idx));
        finished = 1'b1;
      end else begin
        if (!first) compare_value("retire_o spacing", 32'd4, 32'(cycles + 1));
        first = 1'b0;
        compare_value("pc_o", 32'(idx * 4), pc_i);        // Address being executed
        compare_value("wb_valid_o", 32'(exp_we_i), 32'(wb_valid_i));
        if (exp_we_i) begin
          compare_value("wb_addr_o", 32'(exp_reg_i), 32'(wb_addr_i));
          compare_value("wb_data_o", exp_val_i, wb_data_i);
        end
        @(negedge clk);                                    // Flags and PC now updated
        compare_value("flags_o", 32'(exp_flags_i), 32'(flags_i));
        compare_value("pc_o (next)", exp_pc_i, pc_i);
        close_test($sformatf("row %0d", idx));
        if (idx == int'(last_row_i)) finished = 1'b1;
        else idx = int'(exp_pc_i >> 2);
      end
    end
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

/* src/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_arch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         run_i,
  input  wire         imem_we_i,
  input  wire  [5:0]  imem_addr_i,
  input  wire  [31:0] imem_data_i,
  output logic [31:0] pc_o,
  output logic        retire_o,
  output logic        wb_valid_o,
  output logic [3:0]  wb_addr_o,
  output logic [31:0] wb_data_o,
  output logic [3:0]  flags_o
);

  logic [XLEN-1:0] pc, inst, inst_q;
  logic [3:0]      ra_a, ra_b, wa;
  logic [XLEN-1:0] rd_a, rd_b, wdata;
  logic            reg_we, dmem_we, pc_step, take_branch;
  logic [XLEN-1:0] alu_res, mem_addr, dmem_rdata;
  logic            alu_c, alu_v;
  logic [3:0]      flags;                 // N Z C V

  cpu_control i_control (
    .clk, .rst_n_i, .run_i,
    .inst_i(inst), .alu_res_i(alu_res), .alu_c_i(alu_c), .alu_v_i(alu_v),
    .dmem_rdata_i(dmem_rdata), .pc_i(pc),
    .inst_o(inst_q), .ra_a_o(ra_a), .ra_b_o(ra_b), .wa_o(wa), .wdata_o(wdata),
    .reg_we_o(reg_we), .dmem_we_o(dmem_we), .pc_step_o(pc_step),
    .take_branch_o(take_branch), .retire_o(retire_o), .flags_o(flags)
  );

  cpu_pc i_pc (
    .clk, .rst_n_i, .step_i(pc_step), .take_branch_i(take_branch),
    .offset_i(inst_q[BR_OFF_LSB +: BR_OFF_W]), .pc_o(pc)
  );

  cpu_regfile i_regfile (
    .clk, .rst_n_i, .ra_a_i(ra_a), .ra_b_i(ra_b),
    .we_i(reg_we), .wa_i(wa), .wdata_i(wdata),
    .rd_a_o(rd_a), .rd_b_o(rd_b)
  );

  cpu_alu i_alu (
    .inst_i(inst_q), .rm_i(rd_a), .rn_i(rd_b), .c_flag_i(flags[1]),
    .res_o(alu_res), .c_o(alu_c), .v_o(alu_v), .addr_o(mem_addr)
  );

  cpu_memory i_memory (
    .clk, .imem_we_i, .imem_addr_i, .imem_data_i, .pc_i(pc),
    .dmem_we_i(dmem_we), .dmem_addr_i(mem_addr), .dmem_wdata_i(rd_a),  // Store data is rd
    .inst_o(inst), .dmem_rdata_o(dmem_rdata)
  );

  // Write-back observation
  assign wb_valid_o = reg_we;
  assign wb_addr_o  = wa;
  assign wb_data_o  = wdata;
  assign pc_o       = pc;
  assign flags_o    = flags;

endmodule

`default_nettype wire

/* src/cpu_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_memory
  import cpu_arch_pkg::*;
(
  input  wire         clk,
  input  wire         imem_we_i,
  input  wire  [5:0]  imem_addr_i,
  input  wire  [31:0] imem_data_i,
  input  wire  [31:0] pc_i,
  input  wire         dmem_we_i,
  input  wire  [31:0] dmem_addr_i,
  input  wire  [31:0] dmem_wdata_i,
  output logic [31:0] inst_o,
  output logic [31:0] dmem_rdata_o
);

  logic [XLEN-1:0]   imem [MEM_WORDS];   // Program
  logic [XLEN-1:0]   dmem [MEM_WORDS];   // Data
  logic [MEM_AW-1:0] pc_word, d_word;

  // Byte address to word index
  assign pc_word = pc_i[MEM_AW+1:2];
  assign d_word  = dmem_addr_i[MEM_AW+1:2];

  always_ff @(posedge clk) begin
    if (imem_we_i) imem[imem_addr_i] <= imem_data_i;  // Load port, idle only
    if (dmem_we_i) dmem[d_word] <= dmem_wdata_i;      // Store
  end

  assign inst_o       = imem[pc_word];
  assign dmem_rdata_o = dmem[d_word];

endmodule

`default_nettype wire

/* src/cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_alu
  import cpu_isa_pkg::*;
  import cpu_arch_pkg::*;
(
  input  wire  [31:0] inst_i,
  input  wire  [31:0] rm_i,
  input  wire  [31:0] rn_i,
  input  wire         c_flag_i,
  output logic [31:0] res_o,
  output logic        c_o,
  output logic        v_o,
  output logic [31:0] addr_o
);

  cpu_class_e        cls;
  cpu_opcode_e       opc;
  logic [IMM8_W-1:0]  imm8;
  logic [ROT_W-1:0]   rot;
  logic [SHAMT_W-1:0] shamt;
  logic [1:0]         shtype;
  logic [2*XLEN-1:0]  imm_dbl;      // Doubled word for rotate
  logic [2*XLEN-1:0]  rm_dbl;
  logic [XLEN-1:0]    imm_rot, rm_shift, op2;
  logic [XLEN-1:0]    b_in;         // Adder operand, inverted for sub
  logic [XLEN:0]      sum;          // Carry in top bit
  logic [XLEN-1:0]    offset;
  logic               is_sub, is_arith;

  assign cls    = cpu_class_e'(inst_i[CLS_LSB +: CLS_W]);
  assign opc    = cpu_opcode_e'(inst_i[OPC_LSB +: OPC_W]);
  assign imm8   = inst_i[IMM8_LSB +: IMM8_W];
  assign rot    = inst_i[ROT_LSB +: ROT_W];
  assign shamt  = inst_i[SHAMT_LSB +: SHAMT_W];
  assign shtype = inst_i[SHTYPE_LSB +: 2];

  // ************************************************************************
  // Operand 2
  // ************************************************************************
  assign imm_dbl = {2{{(XLEN-IMM8_W){1'b0}}, imm8}} >> {rot, 1'b0};  // ROR by 2*rot
  assign imm_rot = imm_dbl[XLEN-1:0];
  assign rm_dbl  = {rm_i, rm_i} >> shamt;

  always_comb begin
    case (shtype)
      SH_LSL:  rm_shift = rm_i << shamt;
      SH_LSR:  rm_shift = rm_i >> shamt;
      SH_ASR:  rm_shift = $signed(rm_i) >>> shamt;
      SH_ROR:  rm_shift = rm_dbl[XLEN-1:0];
      default: rm_shift = rm_i;
    endcase
  end

  assign op2 = (cls == CLS_DP_IMM) ? imm_rot : rm_shift;

  // ************************************************************************
  // Adder and result
  // ************************************************************************
  assign is_sub   = (opc == OP_SUB) || (opc == OP_CMP);
  assign is_arith = is_sub || (opc == OP_ADD);
  assign b_in     = is_sub ? ~op2 : op2;
  assign sum      = {1'b0, rn_i} + {1'b0, b_in} + {{XLEN{1'b0}}, is_sub};  // Two's complement sub

  always_comb begin
    case (opc)
      OP_AND, OP_TST:         res_o = rn_i & op2;
      OP_EOR, OP_TEQ:         res_o = rn_i ^ op2;
      OP_SUB, OP_ADD, OP_CMP: res_o = sum[XLEN-1:0];
      OP_ORR:                 res_o = rn_i | op2;
      OP_MOV:                 res_o = op2;
      OP_BIC:                 res_o = rn_i & ~op2;
      OP_MVN:                 res_o = ~op2;
      default:                res_o = '0;             // Unsupported opcode
    endcase
  end

  // Carry out of the adder, else unchanged
  assign c_o = is_arith ? sum[XLEN] : c_flag_i;
  // Same-sign operands giving a different-sign result
  assign v_o = (rn_i[XLEN-1] == b_in[XLEN-1]) && (sum[XLEN-1] != rn_i[XLEN-1]);

  // Load/store address, rn +/- offset
  assign offset = XLEN'(inst_i[OFFSET_LSB +: OFFSET_W]);
  assign addr_o = inst_i[U_BIT] ? (rn_i + offset) : (rn_i - offset);

endmodule

`default_nettype wire

/* src/cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile
  import cpu_arch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire  [3:0]  ra_a_i,
  input  wire  [3:0]  ra_b_i,
  input  wire         we_i,
  input  wire  [3:0]  wa_i,
  input  wire  [31:0] wdata_i,
  output logic [31:0] rd_a_o,
  output logic [31:0] rd_b_o
);

  logic [XLEN-1:0] regs [NUM_REGS];  // r0..r15

  // Write port, one register per cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i) begin
      regs[wa_i] <= wdata_i;
    end
  end

  // Read ports, combinational
  assign rd_a_o = regs[ra_a_i];      // rm, or rd for stores
  assign rd_b_o = regs[ra_b_i];      // rn

endmodule

`default_nettype wire

/* src/cpu_pc.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_pc
  import cpu_arch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         step_i,
  input  wire         take_branch_i,
  input  wire  [23:0] offset_i,
  output logic [31:0] pc_o
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;
  logic [XLEN-1:0] branch_off;     // Byte offset

  assign branch_off = {{6{offset_i[23]}}, offset_i, 2'b00};  // Sign-extend, times four

  always_comb begin
    if (take_branch_i) pc_next = pc_q + XLEN'(BRANCH_BIAS) + branch_off;
    else               pc_next = pc_q + XLEN'(PC_STEP);
  end

  // Wraps modulo instruction memory bytes
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= '0;
    end else if (step_i) begin
      pc_q <= {{(XLEN-MEM_AW-2){1'b0}}, pc_next[MEM_AW+1:0]};
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

/* src/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control
  import cpu_isa_pkg::*;
  import cpu_arch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         run_i,
  input  wire  [31:0] inst_i,
  input  wire  [31:0] alu_res_i,
  input  wire         alu_c_i,
  input  wire         alu_v_i,
  input  wire  [31:0] dmem_rdata_i,
  input  wire  [31:0] pc_i,
  output logic [31:0] inst_o,
  output logic [3:0]  ra_a_o,
  output logic [3:0]  ra_b_o,
  output logic [3:0]  wa_o,
  output logic [31:0] wdata_o,
  output logic        reg_we_o,
  output logic        dmem_we_o,
  output logic        pc_step_o,
  output logic        take_branch_o,
  output logic        retire_o,
  output logic [3:0]  flags_o
);

  cpu_state_e      state_q, state_d;
  logic [XLEN-1:0] inst_q;            // Held for the whole instruction
  logic [3:0]      flags_q;           // N Z C V
  cpu_class_e      cls;
  cpu_opcode_e     opc;
  cpu_cond_e       cond;
  logic            n, z, c, v;
  logic            cond_ok;
  logic            is_dp, is_ldst, is_load, is_branch, is_test, is_arith;
  logic            writes_reg, sets_flags;

  assign cls  = cpu_class_e'(inst_q[CLS_LSB +: CLS_W]);
  assign opc  = cpu_opcode_e'(inst_q[OPC_LSB +: OPC_W]);
  assign cond = cpu_cond_e'(inst_q[COND_LSB +: COND_W]);
  assign {n, z, c, v} = flags_q;

  // ************************************************************************
  // Step sequencer
  // ************************************************************************
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:  if (run_i) state_d = ST_FETCH;
      ST_FETCH: state_d = ST_READ;
      ST_READ:  state_d = ST_EXEC;
      ST_EXEC:  state_d = ST_WRITE;
      ST_WRITE: state_d = run_i ? ST_FETCH : ST_IDLE;  // Stop only between instructions
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) state_q <= ST_IDLE;
    else          state_q <= state_d;
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_FETCH) inst_q <= inst_i;          // Latch fetched word
  end

  // Condition check against current flags
  always_comb begin
    case (cond)
      EQ:      cond_ok = z;
      NE:      cond_ok = !z;
      CS:      cond_ok = c;
      CC:      cond_ok = !c;
      MI:      cond_ok = n;
      PL:      cond_ok = !n;
      VS:      cond_ok = v;
      VC:      cond_ok = !v;
      HI:      cond_ok = c && !z;
      LS:      cond_ok = !c || z;
      GE:      cond_ok = (n == v);
      LT:      cond_ok = (n != v);
      GT:      cond_ok = !z && (n == v);
      LE:      cond_ok = z || (n != v);
      AL:      cond_ok = 1'b1;
      default: cond_ok = 1'b0;                           // Never
    endcase
  end

  // Decode
  assign is_dp     = (cls == CLS_DP_REG) || (cls == CLS_DP_IMM);
  assign is_ldst   = (cls == CLS_LDST);
  assign is_load   = is_ldst && inst_q[L_BIT];
  assign is_branch = (cls == CLS_BRANCH);
  assign is_test   = (opc == OP_TST) || (opc == OP_TEQ) || (opc == OP_CMP);
  assign is_arith  = (opc == OP_ADD) || (opc == OP_SUB) || (opc == OP_CMP);

  assign writes_reg = (is_dp && !is_test) || is_load || (is_branch && inst_q[LINK_BIT]);
  assign sets_flags = is_dp && inst_q[S_BIT] && (opc != OP_BIC);

  // ************************************************************************
  // Flag register updated on the edge ending WRITE
  // ************************************************************************
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      flags_q <= '0;
    end else if (state_q == ST_WRITE && sets_flags && cond_ok) begin
      flags_q[3] <= alu_res_i[XLEN-1];                   // N
      flags_q[2] <= (alu_res_i == '0);                   // Z
      flags_q[1] <= alu_c_i;                             // C passed through for logical ops
      if (is_arith) begin
        flags_q[0] <= alu_v_i;                           // V
      end
    end
  end

  // Stores read rd on port A
  assign ra_a_o = is_ldst ? inst_q[RD_LSB +: REG_W] : inst_q[RM_LSB +: REG_W];
  assign ra_b_o = inst_q[RN_LSB +: REG_W];
  assign wa_o   = is_branch ? 4'(LINK_REG) : inst_q[RD_LSB +: REG_W];

  // Write-back mux
  always_comb begin
    if (is_load)        wdata_o = dmem_rdata_i;
    else if (is_branch) wdata_o = pc_i + XLEN'(PC_STEP);  // Link value
    else                wdata_o = alu_res_i;
  end

  assign reg_we_o      = (state_q == ST_WRITE) && cond_ok && writes_reg;
  assign dmem_we_o     = (state_q == ST_EXEC) && cond_ok && is_ldst && !inst_q[L_BIT];
  assign pc_step_o     = (state_q == ST_WRITE);
  assign take_branch_o = (state_q == ST_WRITE) && cond_ok && is_branch;
  assign retire_o      = (state_q == ST_WRITE);           // Also for skipped ones
  assign inst_o        = inst_q;
  assign flags_o       = flags_q;

endmodule

`default_nettype wire

/* src/cpu_arch_pkg.sv */
`default_nettype none

package cpu_arch_pkg;

  // Step sequencer states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,  // Waiting for run
    ST_FETCH = 3'd1,  // Latch instruction
    ST_READ  = 3'd2,  // Register read
    ST_EXEC  = 3'd3,  // ALU or memory access
    ST_WRITE = 3'd4   // Write-back, PC update
  } cpu_state_e;

  // ************************************************************************
  // Sizes
  // ************************************************************************
  localparam int XLEN     = 32;   // Data width
  localparam int NUM_REGS = 16;   // Register file depth

  localparam int MEM_WORDS = 64;  // Words per memory
  localparam int MEM_AW    = 6;   // Word address width

  localparam int LINK_REG = 14;   // Branch-with-link target

  // PC arithmetic
  localparam int PC_STEP     = 4;
  localparam int BRANCH_BIAS = 8; // PC reads two words ahead

endpackage

`default_nettype wire

/* src/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  // Data-processing opcode, bits 24..21
  typedef enum logic [3:0] {
    OP_AND = 4'b0000,
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_TST = 4'b1000,
    OP_TEQ = 4'b1001,
    OP_CMP = 4'b1010,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101,
    OP_BIC = 4'b1110,
    OP_MVN = 4'b1111
  } cpu_opcode_e;

  // Instruction class, bits 27..25
  typedef enum logic [2:0] {
    CLS_DP_REG = 3'b000,
    CLS_DP_IMM = 3'b001,
    CLS_LDST   = 3'b010,
    CLS_BRANCH = 3'b101
  } cpu_class_e;

  // Condition field, 1111 is never
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC, HI, LS, GE, LT, GT, LE, AL
  } cpu_cond_e;

  // ************************************************************************
  // Field positions
  // ************************************************************************
  localparam int COND_LSB   = 28, COND_W = 4;
  localparam int CLS_LSB    = 25, CLS_W = 3;
  localparam int OPC_LSB    = 21, OPC_W = 4;
  localparam int LINK_BIT   = 24;                 // Branch with link
  localparam int U_BIT      = 23;                 // Add offset when set
  localparam int S_BIT      = 20;                 // Set flags
  localparam int L_BIT      = 20;                 // Load when set, same bit as S
  localparam int RN_LSB     = 16, RD_LSB = 12, RM_LSB = 0, REG_W = 4;
  localparam int ROT_LSB    = 8,  ROT_W = 4;
  localparam int IMM8_LSB   = 0,  IMM8_W = 8;
  localparam int SHAMT_LSB  = 7,  SHAMT_W = 5;
  localparam int SHTYPE_LSB = 5;                  // Two bits
  localparam int OFFSET_LSB = 0,  OFFSET_W = 12;  // Load/store offset
  localparam int BR_OFF_LSB = 0,  BR_OFF_W = 24;  // Branch word offset

  // Shift types
  localparam logic [1:0] SH_LSL = 2'b00;
  localparam logic [1:0] SH_LSR = 2'b01;
  localparam logic [1:0] SH_ASR = 2'b10;
  localparam logic [1:0] SH_ROR = 2'b11;

endpackage

`default_nettype wire
